//--- source/dmaPkg.sv
`default_nettype none

package dmaPkg;

	// width of the cpu data bus and of one register byte
	localparam int DataWidth = 8;

	// address and word count registers are two bytes wide
	localparam int AddrWidth = 2 * DataWidth;

	// cpu register select input
	localparam int RegSelWidth = 4;

	// one-hot transfer states
	// idle, wait for hold, drive address, memory access, register update
	typedef enum logic [4:0]
	{
		stateIdle    = 5'b00001,
		stateRequest = 5'b00010,
		stateAddress = 5'b00100,
		stateAccess  = 5'b01000,
		stateUpdate  = 5'b10000
	} dmaState;

	// register map
	// selects below 8 are the channel address and count registers
	// command is write only, status is read only, both sit at 8
	localparam logic [RegSelWidth-1:0] RegCommand = 4'd8;
	localparam logic [RegSelWidth-1:0] RegStatus = 4'd8;
	localparam logic [RegSelWidth-1:0] RegMode = 4'd11;
	localparam logic [RegSelWidth-1:0] RegClearPointer = 4'd12;

	// command bit, set for rotating priority
	localparam int CmdRotatingBit = 0;

	// mode bit, set for memory write and clear for memory read
	localparam int ModeWriteBit = 2;

endpackage

`default_nettype wire

//--- source/dmaChannelIf.sv
`default_nettype none

// link between the register file and the transfer control
// carries the state of the channel being serviced
interface dmaChannelIf #(
	parameter int NumChannels = 4
);
	import dmaPkg::*;

	localparam int ChanWidth = $clog2(NumChannels);

	// channel latched by the control on serve
	logic [ChanWidth-1:0] chanSel;
	// one-cycle strobe in the update state
	logic update;
	// current registers of chanSel
	logic [AddrWidth-1:0] curAddr;
	logic [AddrWidth-1:0] curCount;
	// mode bit of chanSel, high for memory write
	logic writeDir;

	// register side answers the selected channel and applies updates
	modport regs (
		input  chanSel,
		input  update,
		output curAddr,
		output curCount,
		output writeDir
	);

	// control side picks the channel and fires the update
	modport ctrl (
		output chanSel,
		output update,
		input  curAddr,
		input  curCount,
		input  writeDir
	);

endinterface

`default_nettype wire

//--- source/dmaRegisterFile.sv
`default_nettype none

module dmaRegisterFile #(
	parameter int NumChannels = 4
) (
	input  logic                           busIf,
	input  logic                           rst,
	input  logic                           csN,
	input  logic                           iorN,
	input  logic                           iowN,
	input  logic                           idle,
	input  logic [dmaPkg::RegSelWidth-1:0] regSel,
	input  logic [dmaPkg::DataWidth-1:0]   dbIn,
	output logic [dmaPkg::DataWidth-1:0]   dbOut,
	output logic [NumChannels-1:0]         eligible,
	output logic                           rotating,
	dmaChannelIf.regs                      chanPort
);
	import dmaPkg::*;

	localparam int ChanWidth = $clog2(NumChannels);

	// per-channel current address and word count
	logic [AddrWidth-1:0] addrReg [NumChannels];
	logic [AddrWidth-1:0] countReg [NumChannels];
	// direction per channel, high means memory write
	logic [NumChannels-1:0] modeWrite;
	// terminal count bits as the cpu sees them, cleared by a status read
	logic [NumChannels-1:0] tcStatus;
	// terminal count kept until the count is rewritten
	logic [NumChannels-1:0] tcMask;
	// command register, only the priority type is kept
	logic cmdRotating;
	// byte pointer flip-flop, low byte first
	logic bytePtr;

	logic cpuWrite;
	logic cpuRead;
	logic chanAccess;
	logic [ChanWidth-1:0] selChan;
	logic [AddrWidth-1:0] chanWord;
	logic [DataWidth-1:0] readByte;

	// port only answers while the controller sits idle
	assign cpuWrite = !csN && !iowN && idle;
	assign cpuRead = !csN && !iorN && idle;
	// selects below the command slot address a channel register
	assign chanAccess = regSel < RegCommand;
	assign selChan = regSel[ChanWidth:1];

	// select bit 0 picks count over address
	assign chanWord = regSel[0] ? countReg[selChan] : addrReg[selChan];
	assign readByte = bytePtr ? chanWord[AddrWidth-1:DataWidth] : chanWord[DataWidth-1:0];

	// view of the serviced channel for the transfer control
	assign chanPort.curAddr = addrReg[chanPort.chanSel];
	assign chanPort.curCount = countReg[chanPort.chanSel];
	assign chanPort.writeDir = modeWrite[chanPort.chanSel];

	assign eligible = ~tcMask;
	assign rotating = cmdRotating;

	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			for (int i = 0; i < NumChannels; i++)
			begin
				addrReg[i] <= '0;
				countReg[i] <= '0;
			end
			modeWrite <= '0;
			tcStatus <= '0;
			tcMask <= '0;
			cmdRotating <= 1'b0;
			bytePtr <= 1'b0;
			dbOut <= '0;
		end
		else
		begin
			if (cpuWrite)
			begin
				if (chanAccess)
				begin
					if (regSel[0])
					begin
						if (bytePtr)
							countReg[selChan][AddrWidth-1:DataWidth] <= dbIn;
						else
							countReg[selChan][DataWidth-1:0] <= dbIn;
						// rewriting the count makes the channel eligible again
						tcMask[selChan] <= 1'b0;
					end
					else if (bytePtr)
						addrReg[selChan][AddrWidth-1:DataWidth] <= dbIn;
					else
						addrReg[selChan][DataWidth-1:0] <= dbIn;
					bytePtr <= !bytePtr;
				end
				else if (regSel == RegCommand)
					cmdRotating <= dbIn[CmdRotatingBit];
				else if (regSel == RegMode)
					modeWrite[dbIn[ChanWidth-1:0]] <= dbIn[ModeWriteBit];
				else if (regSel == RegClearPointer)
					bytePtr <= 1'b0;
			end
			if (cpuRead)
			begin
				if (chanAccess)
				begin
					dbOut <= readByte;
					bytePtr <= !bytePtr;
				end
				else if (regSel == RegStatus)
				begin
					// status read returns and clears the tc bits in one edge
					dbOut <= DataWidth'(tcStatus);
					tcStatus <= '0;
				end
				else
				begin
					dbOut <= '0;
					if (regSel == RegClearPointer)
						bytePtr <= 1'b0;
				end
			end
			// update strobe only comes outside idle, so no clash with the cpu
			if (chanPort.update)
			begin
				addrReg[chanPort.chanSel] <= chanPort.curAddr + 1'b1;
				countReg[chanPort.chanSel] <= chanPort.curCount - 1'b1;
				if (chanPort.curCount == '0)
				begin
					tcStatus[chanPort.chanSel] <= 1'b1;
					tcMask[chanPort.chanSel] <= 1'b1;
				end
			end
		end
	end

	// cpu never reads and writes in the same cycle
	noReadWriteTogether: assert property (@(posedge busIf) disable iff (rst)
		!csN |-> !(!iorN && !iowN));

endmodule

`default_nettype wire

//--- source/dmaPriorityArbiter.sv
`default_nettype none

module dmaPriorityArbiter #(
	parameter int NumChannels = 4
) (
	input  logic                           busIf,
	input  logic                           rst,
	input  logic [NumChannels-1:0]         dreq,
	input  logic [NumChannels-1:0]         eligible,
	input  logic                           rotating,
	input  logic                           serve,
	output logic                           reqValid,
	output logic [$clog2(NumChannels)-1:0] grantChan
);

	localparam int ChanWidth = $clog2(NumChannels);

	// channels with a request that have not hit terminal count
	logic [NumChannels-1:0] masked;
	// highest priority channel in rotating mode
	logic [ChanWidth-1:0] topChan;
	// where the search begins
	logic [ChanWidth-1:0] startChan;

	assign masked = dreq & eligible;

	// fixed priority always starts at channel 0
	assign startChan = rotating ? topChan : '0;

	// walk the channels once from startChan, first hit wins
	always_comb
	begin
		int idx;
		reqValid = 1'b0;
		grantChan = '0;
		for (int i = 0; i < NumChannels; i++)
		begin
			idx = int'(startChan) + i;
			if (idx >= NumChannels)
				idx = idx - NumChannels;
			if (!reqValid && masked[idx])
			begin
				reqValid = 1'b1;
				grantChan = ChanWidth'(idx);
			end
		end
	end

	// served channel drops to lowest priority
	// rotation holds still in fixed mode so rotating starts from channel 0
	always_ff @(posedge busIf)
	begin
		if (rst)
			topChan <= '0;
		else if (serve && rotating)
		begin
			if (grantChan == ChanWidth'(NumChannels - 1))
				topChan <= '0;
			else
				topChan <= grantChan + 1'b1;
		end
	end

	// control only takes a channel the arbiter is offering
	serveNeedsRequest: assert property (@(posedge busIf) disable iff (rst)
		serve |-> reqValid);

endmodule

`default_nettype wire

//--- source/dmaTransferControl.sv
`default_nettype none

module dmaTransferControl #(
	parameter int NumChannels = 4
) (
	input  logic                           busIf,
	input  logic                           rst,
	input  logic                           reqValid,
	input  logic [$clog2(NumChannels)-1:0] grantChan,
	input  logic                           hlda,
	output logic                           serve,
	output logic                           idle,
	output logic                           hrq,
	output logic                           aen,
	output logic                           adstb,
	output logic [NumChannels-1:0]         dack,
	output logic [dmaPkg::AddrWidth-1:0]   addrOut,
	output logic                           memrN,
	output logic                           memwN,
	dmaChannelIf.ctrl                      chanPort
);
	import dmaPkg::*;

	dmaState state;
	dmaState nextState;

	// decoded state flags
	logic inAccess;
	logic inUpdate;

	// next state
	always_comb
	begin
		nextState = state;
		unique case (state)
			stateIdle:
			begin
				if (reqValid)
					nextState = stateRequest;
			end
			stateRequest:
			begin
				// wait as long as the cpu keeps the bus
				if (hlda)
					nextState = stateAddress;
			end
			stateAddress:
				nextState = stateAccess;
			stateAccess:
				nextState = stateUpdate;
			stateUpdate:
				nextState = stateIdle;
			default:
				nextState = stateIdle;
		endcase
	end

	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			state <= stateIdle;
			chanPort.chanSel <= '0;
		end
		else
		begin
			state <= nextState;
			// grant is frozen for the whole transfer
			if (serve)
				chanPort.chanSel <= grantChan;
		end
	end

	assign idle = state == stateIdle;
	assign inAccess = state == stateAccess;
	assign inUpdate = state == stateUpdate;

	// pulse on the idle to request edge
	assign serve = idle && reqValid;

	// hold request stays up from request through update
	assign hrq = !idle;
	// bus owned from the address state onward
	assign aen = (state == stateAddress) || inAccess || inUpdate;
	assign adstb = state == stateAddress;
	// full address goes out at once while the bus is owned
	assign addrOut = aen ? chanPort.curAddr : '0;

	// acknowledge covers access and update
	assign dack = (inAccess || inUpdate) ? (NumChannels'(1) << chanPort.chanSel) : '0;

	// single-cycle strobes, direction from the channel mode
	assign memwN = !(inAccess && chanPort.writeDir);
	assign memrN = !(inAccess && !chanPort.writeDir);

	assign chanPort.update = inUpdate;

	// address strobe never stretches
	adstbOneCycle: assert property (@(posedge busIf) disable iff (rst)
		adstb |=> !adstb);

	// at most one channel acknowledged
	dackOneHot: assert property (@(posedge busIf) disable iff (rst)
		$onehot0(dack));

	// read and write strobes never overlap
	memStrobesExclusive: assert property (@(posedge busIf) disable iff (rst)
		!(!memrN && !memwN));

endmodule

`default_nettype wire

//--- source/dmaController.sv
`default_nettype none

module dmaController #(
	parameter int NumChannels = 4
) (
	input  logic                           busIf,
	input  logic                           rst,
	input  logic                           csN,
	input  logic                           iorN,
	input  logic                           iowN,
	input  logic [dmaPkg::RegSelWidth-1:0] regSel,
	input  logic [dmaPkg::DataWidth-1:0]   dbIn,
	input  logic [NumChannels-1:0]         dreq,
	input  logic                           hlda,
	output logic [dmaPkg::DataWidth-1:0]   dbOut,
	output logic                           hrq,
	output logic                           aen,
	output logic                           adstb,
	output logic [NumChannels-1:0]         dack,
	output logic [dmaPkg::AddrWidth-1:0]   addrOut,
	output logic                           memrN,
	output logic                           memwN
);

	// register file to arbiter
	logic [NumChannels-1:0] eligible;
	logic rotating;
	// arbiter and control handshake
	logic reqValid;
	logic [$clog2(NumChannels)-1:0] grantChan;
	logic serve;
	// cpu port gate
	logic idle;

	// serviced channel link
	dmaChannelIf #(.NumChannels(NumChannels)) chanIf ();

	dmaRegisterFile #(.NumChannels(NumChannels)) regFile (
		.busIf    (busIf),
		.rst      (rst),
		.csN      (csN),
		.iorN     (iorN),
		.iowN     (iowN),
		.idle     (idle),
		.regSel   (regSel),
		.dbIn     (dbIn),
		.dbOut    (dbOut),
		.eligible (eligible),
		.rotating (rotating),
		.chanPort (chanIf.regs)
	);

	dmaPriorityArbiter #(.NumChannels(NumChannels)) arbiter (
		.busIf     (busIf),
		.rst       (rst),
		.dreq      (dreq),
		.eligible  (eligible),
		.rotating  (rotating),
		.serve     (serve),
		.reqValid  (reqValid),
		.grantChan (grantChan)
	);

	dmaTransferControl #(.NumChannels(NumChannels)) control (
		.busIf     (busIf),
		.rst       (rst),
		.reqValid  (reqValid),
		.grantChan (grantChan),
		.hlda      (hlda),
		.serve     (serve),
		.idle      (idle),
		.hrq       (hrq),
		.aen       (aen),
		.adstb     (adstb),
		.dack      (dack),
		.addrOut   (addrOut),
		.memrN     (memrN),
		.memwN     (memwN),
		.chanPort  (chanIf.ctrl)
	);

endmodule

`default_nettype wire

//--- test/dmaControllerTb.sv
`default_nettype none

module dmaControllerTb;
	import dmaPkg::*;

	localparam int NumChannels = 4;
	localparam int ChanWidth = $clog2(NumChannels);
	localparam int ClkPeriod = 8;
	localparam int NumRandom = 24;
	// reset, register readback, random transfers, terminal count, rotation
	localparam int NumTests = NumRandom + 13;

	logic busIf = 1'b0;
	logic rst;
	logic csN;
	logic iorN;
	logic iowN;
	logic [RegSelWidth-1:0] regSel;
	logic [DataWidth-1:0] dbIn;
	logic [NumChannels-1:0] dreq;
	logic hlda;
	logic [DataWidth-1:0] dbOut;
	logic hrq;
	logic aen;
	logic adstb;
	logic [NumChannels-1:0] dack;
	logic [AddrWidth-1:0] addrOut;
	logic memrN;
	logic memwN;

	// reference model of the cpu-visible state
	logic [AddrWidth-1:0] modelAddr [NumChannels];
	logic [AddrWidth-1:0] modelCount [NumChannels];
	logic [NumChannels-1:0] modelMode;
	logic [NumChannels-1:0] modelTc;
	logic [NumChannels-1:0] modelMask;
	logic modelRotating;
	logic modelPtr;
	logic [ChanWidth-1:0] modelTop;

	// expected values the assertions compare against
	logic [DataWidth-1:0] expRead;
	logic [AddrWidth-1:0] expAddr;
	logic [NumChannels-1:0] expDack;
	logic expWrite;
	logic expectIdle;
	// read data shows up one edge after the read cycle
	logic readCheck = 1'b0;
	logic [DataWidth-1:0] readExpect = '0;

	logic [31:0] lfsr;
	logic [ChanWidth-1:0] lastChan;
	logic lastValid;

	dmaController #(.NumChannels(NumChannels)) i_dut (
		.busIf   (busIf),
		.rst     (rst),
		.csN     (csN),
		.iorN    (iorN),
		.iowN    (iowN),
		.regSel  (regSel),
		.dbIn    (dbIn),
		.dreq    (dreq),
		.hlda    (hlda),
		.dbOut   (dbOut),
		.hrq     (hrq),
		.aen     (aen),
		.adstb   (adstb),
		.dack    (dack),
		.addrOut (addrOut),
		.memrN   (memrN),
		.memwN   (memwN)
	);

	always #(ClkPeriod / 2) busIf = !busIf;

	always @(posedge busIf)
	begin
		readCheck <= !rst && !csN && !iorN;
		readExpect <= expRead;
	end

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, want);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic reportFailure(input string what);
		$display("error at time %0t: %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	// outputs settle to their idle levels under reset
	resetOutputs: assert property (@(posedge busIf) rst |=>
		(!hrq && !aen && !adstb && dack == '0 && memrN && memwN))
		else reportMismatch("reset outputs", 32'($sampled({hrq, aen, adstb, dack, memrN, memwN})),
			32'({3'b000, {NumChannels{1'b0}}, 2'b11}));

	readData: assert property (@(posedge busIf) disable iff (rst)
		readCheck |-> dbOut == readExpect)
		else reportMismatch("dbOut", 32'($sampled(dbOut)), 32'($sampled(readExpect)));

	// address strobe exactly one cycle after hlda is seen in the request state
	hldaToAdstb: assert property (@(posedge busIf) disable iff (rst)
		(hrq && !aen && hlda) |=> adstb)
		else reportFailure("adstb did not follow the sampled hlda");

	addrAtStrobe: assert property (@(posedge busIf) disable iff (rst)
		adstb |-> addrOut == expAddr)
		else reportMismatch("addrOut", 32'($sampled(addrOut)), 32'($sampled(expAddr)));

	dackInAccess: assert property (@(posedge busIf) disable iff (rst)
		adstb |=> dack == expDack)
		else reportMismatch("dack", 32'($sampled(dack)), 32'($sampled(expDack)));

	// memrN low for a read, memwN low for a write
	strobeInAccess: assert property (@(posedge busIf) disable iff (rst)
		adstb |=> {memrN, memwN} == {expWrite, !expWrite})
		else reportMismatch("memrN/memwN", 32'($sampled({memrN, memwN})),
			32'($sampled({expWrite, !expWrite})));

	accessToUpdate: assert property (@(posedge busIf) disable iff (rst)
		(aen && !adstb && !(memrN && memwN)) |=> (aen && dack == expDack && memrN && memwN))
		else reportFailure("no update cycle after the memory access");

	updateToIdle: assert property (@(posedge busIf) disable iff (rst)
		(aen && !adstb && memrN && memwN) |=> (!hrq && !aen && dack == '0))
		else reportFailure("bus not released after the update cycle");

	// a channel at terminal count is never acknowledged
	noAckAfterTc: assert property (@(posedge busIf) disable iff (rst)
		(dack & modelMask) == '0)
		else reportMismatch("dack & tc mask", 32'($sampled(dack & modelMask)), 32'(0));

	quietBus: assert property (@(posedge busIf) disable iff (rst)
		expectIdle |-> !hrq)
		else reportFailure("hrq raised with no eligible request");

	// Galois step with taps for a maximal 32-bit sequence
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hD0000001;
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic randomBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
	endtask

	function automatic logic [RegSelWidth-1:0] addrSel(input logic [ChanWidth-1:0] c);
		return RegSelWidth'({c, 1'b0});
	endfunction

	function automatic logic [RegSelWidth-1:0] countSel(input logic [ChanWidth-1:0] c);
		return RegSelWidth'({c, 1'b1});
	endfunction

	task automatic writeReg(input logic [RegSelWidth-1:0] sel, input logic [DataWidth-1:0] data);
		logic [ChanWidth-1:0] c;
		c = sel[ChanWidth:1];
		if (sel < RegCommand)
		begin
			if (sel[0] && modelPtr)
				modelCount[c][AddrWidth-1:DataWidth] = data;
			else if (sel[0])
				modelCount[c][DataWidth-1:0] = data;
			else if (modelPtr)
				modelAddr[c][AddrWidth-1:DataWidth] = data;
			else
				modelAddr[c][DataWidth-1:0] = data;
			// new count makes the channel eligible again
			if (sel[0])
				modelMask[c] = 1'b0;
			modelPtr = !modelPtr;
		end
		else if (sel == RegCommand)
			modelRotating = data[CmdRotatingBit];
		else if (sel == RegMode)
			modelMode[data[ChanWidth-1:0]] = data[ModeWriteBit];
		else if (sel == RegClearPointer)
			modelPtr = 1'b0;
		csN = 1'b0;
		iowN = 1'b0;
		regSel = sel;
		dbIn = data;
		@(posedge busIf);
		#1;
		csN = 1'b1;
		iowN = 1'b1;
	endtask

	task automatic readReg(input logic [RegSelWidth-1:0] sel);
		logic [ChanWidth-1:0] c;
		logic [AddrWidth-1:0] word;
		c = sel[ChanWidth:1];
		if (sel < RegCommand)
		begin
			word = sel[0] ? modelCount[c] : modelAddr[c];
			expRead = modelPtr ? word[AddrWidth-1:DataWidth] : word[DataWidth-1:0];
			modelPtr = !modelPtr;
		end
		else if (sel == RegStatus)
		begin
			// reading status also clears it
			expRead = DataWidth'(modelTc);
			modelTc = '0;
		end
		else
		begin
			expRead = '0;
			if (sel == RegClearPointer)
				modelPtr = 1'b0;
		end
		csN = 1'b0;
		iorN = 1'b0;
		regSel = sel;
		@(posedge busIf);
		#1;
		csN = 1'b1;
		iorN = 1'b1;
	endtask

	task automatic writeWord(input logic [RegSelWidth-1:0] sel, input logic [AddrWidth-1:0] v);
		writeReg(sel, v[DataWidth-1:0]);
		writeReg(sel, v[AddrWidth-1:DataWidth]);
	endtask

	task automatic readWord(input logic [RegSelWidth-1:0] sel);
		readReg(sel);
		readReg(sel);
	endtask

	// expected winner among eligible requests
	task automatic pickChannel(input logic [NumChannels-1:0] reqs, output logic found,
		output logic [ChanWidth-1:0] chan);
		logic [NumChannels-1:0] masked;
		logic [ChanWidth-1:0] start;
		logic [ChanWidth-1:0] idx;
		masked = reqs & ~modelMask;
		start = modelRotating ? modelTop : '0;
		found = 1'b0;
		chan = '0;
		for (int i = 0; i < NumChannels; i++)
		begin
			idx = ChanWidth'((int'(start) + i) % NumChannels);
			if (!found && masked[idx])
			begin
				found = 1'b1;
				chan = idx;
			end
		end
	endtask

	task automatic runTransfer(input logic [NumChannels-1:0] reqs);
		logic found;
		logic [ChanWidth-1:0] chan;
		logic [31:0] delay;
		pickChannel(reqs, found, chan);
		randomBits(2, delay);
		lastChan = chan;
		lastValid = found;
		dreq = reqs;
		if (!found)
		begin
			// nothing eligible so the bus must stay quiet
			expectIdle = 1'b1;
			repeat (4) @(posedge busIf);
			#1;
			dreq = '0;
			expectIdle = 1'b0;
		end
		else
		begin
			expDack = NumChannels'(1) << chan;
			expAddr = modelAddr[chan];
			expWrite = modelMode[chan];
			do
			begin
				@(posedge busIf);
				#1;
			end
			while (!hrq);
			// hold acknowledge comes a few random cycles late
			repeat (delay[1:0]) @(posedge busIf);
			#1;
			hlda = 1'b1;
			@(posedge busIf);
			#1;
			dreq = '0;
			while (hrq)
			begin
				@(posedge busIf);
				#1;
			end
			hlda = 1'b0;
			if (modelCount[chan] == '0)
			begin
				modelTc[chan] = 1'b1;
				modelMask[chan] = 1'b1;
			end
			modelAddr[chan] = modelAddr[chan] + 1'b1;
			modelCount[chan] = modelCount[chan] - 1'b1;
			if (modelRotating)
				modelTop = chan + 1'b1;
		end
	endtask

	initial
	begin
		#(NumTests * 40 * ClkPeriod);
		$display("timeout: tests did not finish within %0d cycles", NumTests * 40);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		logic [31:0] bits;
		logic [DataWidth-1:0] mode;
		logic [NumChannels-1:0] reqs;
		rst = 1'b1;
		csN = 1'b1;
		iorN = 1'b1;
		iowN = 1'b1;
		regSel = '0;
		dbIn = '0;
		dreq = '0;
		hlda = 1'b0;
		expRead = '0;
		expAddr = '0;
		expDack = '0;
		expWrite = 1'b0;
		expectIdle = 1'b0;
		lfsr = 32'h854ad86b;
		lastChan = '0;
		lastValid = 1'b0;
		for (int c = 0; c < NumChannels; c++)
		begin
			modelAddr[c] = '0;
			modelCount[c] = '0;
		end
		modelMode = '0;
		modelTc = '0;
		modelMask = '0;
		modelRotating = 1'b0;
		modelPtr = 1'b0;
		modelTop = '0;
		repeat (4) @(posedge busIf);
		#1;
		rst = 1'b0;

		readReg(RegStatus);

		// program every channel with random values and a random direction
		for (int c = 0; c < NumChannels; c++)
		begin
			randomBits(16, bits);
			writeWord(addrSel(ChanWidth'(c)), bits[AddrWidth-1:0]);
			randomBits(16, bits);
			writeWord(countSel(ChanWidth'(c)), bits[AddrWidth-1:0]);
			randomBits(1, bits);
			mode = '0;
			mode[ModeWriteBit] = bits[0];
			mode[ChanWidth-1:0] = ChanWidth'(c);
			writeReg(RegMode, mode);
		end
		for (int c = 0; c < NumChannels; c++)
		begin
			readWord(addrSel(ChanWidth'(c)));
			readWord(countSel(ChanWidth'(c)));
		end
		// half a write, then clear pointer puts reads back on the low byte
		writeReg(addrSel(1), 8'h5a);
		writeReg(RegClearPointer, 8'h00);
		readWord(addrSel(1));

		// fixed priority with random request patterns
		repeat (NumRandom)
		begin
			randomBits(NumChannels, bits);
			reqs = bits[NumChannels-1:0];
			if (reqs == '0)
				reqs = NumChannels'(1);
			runTransfer(reqs);
			if (lastValid)
			begin
				writeReg(RegClearPointer, 8'h00);
				readWord(addrSel(lastChan));
				readWord(countSel(lastChan));
			end
		end

		// count zero hits terminal count after one transfer
		writeReg(RegClearPointer, 8'h00);
		writeWord(countSel(2), 16'h0000);
		runTransfer(4'b0100);
		runTransfer(4'b0100);
		runTransfer(4'b0110);
		readReg(RegStatus);
		readReg(RegStatus);
		writeWord(countSel(2), 16'h0003);
		runTransfer(4'b0100);

		// rotating priority with every request held
		writeReg(RegCommand, 8'h01);
		repeat (5) runTransfer(4'b1111);

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dmaController.f
source/dmaPkg.sv
source/dmaChannelIf.sv
source/dmaRegisterFile.sv
source/dmaPriorityArbiter.sv
source/dmaTransferControl.sv
source/dmaController.sv
test/dmaControllerTb.sv

//--- run.sh
#!/bin/sh
# compile the dmaController testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module dmaControllerTb \
	-f dmaController.f -Mdir obj_dir
./obj_dir/VdmaControllerTb 2>&1 | tee sim.log
if grep -q "Simulation passed" sim.log
then
	echo "run.sh: PASS"
else
	echo "run.sh: FAIL"
	exit 1
fi
